//--- cam_udp_pkg.sv
// shared types, APB register map and frame layout; payload length must stay within 18..1472
`default_nettype none

package cam_udp_pkg;

    typedef logic [7:0]  byte_t;     // pixel and GMII byte
    typedef logic [10:0] len_t;      // udp payload length
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;
    typedef logic [5:0]  apb_addr_t; // byte address

    // register map
    localparam apb_addr_t REG_CTRL    = 6'h00; // bit 0 enable
    localparam apb_addr_t REG_LEN     = 6'h04;
    localparam apb_addr_t REG_DMAC_LO = 6'h08;
    localparam apb_addr_t REG_DMAC_HI = 6'h0C;
    localparam apb_addr_t REG_DIP     = 6'h10;
    localparam apb_addr_t REG_SIP     = 6'h14;
    localparam apb_addr_t REG_PORTS   = 6'h18; // src port high, dst port low
    localparam apb_addr_t REG_STAT    = 6'h1C; // frame count, overflow in bit 31

    // frame layout
    localparam int HDR_BYTES      = 42; // eth 14 + ip 20 + udp 8
    localparam int PREAMBLE_BYTES = 8;
    localparam int IFG_CYCLES     = 12;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_VER_IHL    = 8'h45;   // v4, 5 words
    localparam logic [15:0] IP_FLAGS      = 16'h4000; // don't fragment
    localparam byte_t       IP_TTL        = 8'd64;
    localparam byte_t       IP_PROTO_UDP  = 8'd17;

endpackage

`default_nettype wire

//--- apb_cfg_regs.sv
// APB3 slave with pready tied high; unmapped addresses answer with pslverr
`timescale 1ns/10ps
`default_nettype none

module apb_cfg_regs (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire cam_udp_pkg::apb_addr_t paddr,
    input  wire [31:0]                  pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  wire                         overflow,
    input  wire                         frame_done,
    output logic                        enable,
    output cam_udp_pkg::len_t           payload_len,
    output cam_udp_pkg::mac_t           dst_mac,
    output cam_udp_pkg::ip_t            dst_ip,
    output cam_udp_pkg::ip_t            src_ip,
    output cam_udp_pkg::port_t          src_port,
    output cam_udp_pkg::port_t          dst_port,
    output logic                        clr_overflow
);
    import cam_udp_pkg::*;

    logic        wr_en;
    logic        mapped;
    logic [31:0] rd_mux;
    logic [15:0] frame_cnt;

    assign pready = 1'b1;
    assign wr_en  = psel & penable & pwrite;   // access phase

    always_comb begin
        mapped = 1'b1;
        case (paddr)
            REG_CTRL:    rd_mux = {31'd0, enable};
            REG_LEN:     rd_mux = {21'd0, payload_len};
            REG_DMAC_LO: rd_mux = dst_mac[31:0];
            REG_DMAC_HI: rd_mux = {16'd0, dst_mac[47:32]};
            REG_DIP:     rd_mux = dst_ip;
            REG_SIP:     rd_mux = src_ip;
            REG_PORTS:   rd_mux = {src_port, dst_port};
            REG_STAT:    rd_mux = {overflow, 15'd0, frame_cnt};
            default: begin
                rd_mux = '0;
                mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prdata       <= '0;
            pslverr      <= 1'b0;
            clr_overflow <= 1'b0;
            enable       <= 1'b0;
            payload_len  <= 11'd64;
            dst_mac      <= '0;
            dst_ip       <= '0;
            src_ip       <= '0;
            src_port     <= '0;
            dst_port     <= '0;
            frame_cnt    <= '0;
        end else begin
            // setup phase result shows in the access phase
            prdata       <= (psel && !penable && !pwrite) ? rd_mux : '0;
            pslverr      <= psel & ~penable & ~mapped;
            clr_overflow <= wr_en && (paddr == REG_STAT) && pwdata[31];
            if (frame_done)
                frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
            if (wr_en) begin
                case (paddr)
                    REG_CTRL:    enable         <= pwdata[0];
                    REG_LEN:     payload_len    <= pwdata[10:0];
                    REG_DMAC_LO: dst_mac[31:0]  <= pwdata;
                    REG_DMAC_HI: dst_mac[47:32] <= pwdata[15:0];
                    REG_DIP:     dst_ip         <= pwdata;
                    REG_SIP:     src_ip         <= pwdata;
                    REG_PORTS: begin
                        src_port <= pwdata[31:16];
                        dst_port <= pwdata[15:0];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- cam_line_buffer.sv
// camera port must be synchronous to gmii_tx_clk; FIFO_DEPTH a power of two, at most 2048
`timescale 1ns/10ps
`default_nettype none

module cam_line_buffer #(
    parameter int FIFO_DEPTH = 2048
) (
    input  wire                      gmii_tx_clk,
    input  wire                      arst_n,
    input  wire                      enable,
    input  wire cam_udp_pkg::byte_t  cam_data,
    input  wire                      cam_href,
    input  wire                      cam_vsync,
    input  wire                      pay_rd,
    output cam_udp_pkg::byte_t       pay_data,
    output logic [11:0]              fill_level,
    input  wire                      clr_overflow,
    output logic                     overflow
);
    import cam_udp_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [11:0]   count;
    logic          vsync_q;
    logic          armed;
    logic          wr_req;
    logic          full;
    logic          push;

    assign wr_req     = armed & cam_href;
    assign full       = (count == 12'(FIFO_DEPTH));
    assign push       = wr_req & ~full;
    assign fill_level = count;

    always_ff @(posedge gmii_tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q  <= 1'b0;
            armed    <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            vsync_q <= cam_vsync;
            if (enable && vsync_q && !cam_vsync)
                armed <= 1'b1;             // first frame boundary, stays armed
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pay_rd)
                rd_ptr <= rd_ptr + 1'b1;   // reader never pops an empty FIFO
            count <= count + {11'd0, push} - {11'd0, pay_rd};
            if (clr_overflow)
                overflow <= 1'b0;
            if (wr_req && full)
                overflow <= 1'b1;          // dropped pixel wins over clear
        end
    end

    // storage and registered read port
    always_ff @(posedge gmii_tx_clk) begin
        if (push)
            mem[wr_ptr] <= cam_data;
        if (pay_rd)
            pay_data <= mem[rd_ptr];       // valid the cycle after pay_rd
    end

endmodule

`default_nettype wire

//--- udp_header_gen.sv
// header fields are frozen at frame_start; hdr_ready pulses 4 cycles later; no UDP checksum
`timescale 1ns/10ps
`default_nettype none

module udp_header_gen #(
    parameter cam_udp_pkg::mac_t LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  wire                      gmii_tx_clk,
    input  wire                      arst_n,
    input  wire                      frame_start,
    input  wire cam_udp_pkg::len_t   payload_len,
    input  wire cam_udp_pkg::mac_t   dst_mac,
    input  wire cam_udp_pkg::ip_t    dst_ip,
    input  wire cam_udp_pkg::ip_t    src_ip,
    input  wire cam_udp_pkg::port_t  src_port,
    input  wire cam_udp_pkg::port_t  dst_port,
    input  wire [5:0]                hdr_idx,
    output cam_udp_pkg::byte_t       hdr_byte,
    output logic                     hdr_ready
);
    import cam_udp_pkg::*;

    mac_t         dst_mac_q;
    ip_t          dst_ip_q;
    ip_t          src_ip_q;
    port_t        src_port_q;
    port_t        dst_port_q;
    logic [15:0]  tot_len_q;
    logic [15:0]  udp_len_q;
    logic [15:0]  id_q;
    logic [15:0]  ip_id;
    logic [15:0]  tot_len_in;
    logic [19:0]  sum;           // room for nine 16-bit words
    logic [15:0]  ip_csum;
    logic [2:0]   step;
    logic [HDR_BYTES*8-1:0] hdr_vec;

    assign tot_len_in = {5'd0, payload_len} + 16'd28;

    always_ff @(posedge gmii_tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            step      <= '0;
            hdr_ready <= 1'b0;
            ip_id     <= '0;
        end else begin
            step      <= {step[1:0], frame_start};
            hdr_ready <= step[2];             // one pulse when checksum lands
            if (frame_start)
                ip_id <= ip_id + 1'b1;
        end
    end

    // snapshot and checksum pipeline
    always_ff @(posedge gmii_tx_clk) begin
        if (frame_start) begin
            dst_mac_q  <= dst_mac;
            dst_ip_q   <= dst_ip;
            src_ip_q   <= src_ip;
            src_port_q <= src_port;
            dst_port_q <= dst_port;
            tot_len_q  <= tot_len_in;
            udp_len_q  <= {5'd0, payload_len} + 16'd8;
            id_q       <= ip_id;
            sum <= {IP_VER_IHL, 8'h00} + tot_len_in + ip_id + IP_FLAGS
                 + {IP_TTL, IP_PROTO_UDP};
        end
        if (step[0])
            sum <= sum + src_ip_q[31:16] + src_ip_q[15:0]
                 + dst_ip_q[31:16] + dst_ip_q[15:0];
        if (step[1])
            sum <= {4'd0, sum[15:0]} + {16'd0, sum[19:16]}; // first fold
        if (step[2])
            ip_csum <= ~(sum[15:0] + {15'd0, sum[16]});
    end

    // network byte order, index 0 goes out first
    assign hdr_vec = {dst_mac_q, LOCAL_MAC, ETH_TYPE_IPV4,
                      IP_VER_IHL, 8'h00, tot_len_q, id_q, IP_FLAGS,
                      IP_TTL, IP_PROTO_UDP, ip_csum, src_ip_q, dst_ip_q,
                      src_port_q, dst_port_q, udp_len_q, 16'h0000};

    always_comb begin
        if (int'(hdr_idx) < HDR_BYTES)
            hdr_byte = hdr_vec[(HDR_BYTES - 1 - int'(hdr_idx)) * 8 +: 8];
        else
            hdr_byte = '0;
    end

endmodule

`default_nettype wire

//--- gmii_frame_tx.sv
// no GMII back-pressure; a frame starts only once the FIFO already holds the whole payload
`timescale 1ns/10ps
`default_nettype none

module gmii_frame_tx (
    input  wire                      gmii_tx_clk,
    input  wire                      arst_n,
    input  wire                      enable,
    input  wire cam_udp_pkg::len_t   payload_len,
    input  wire [11:0]               fill_level,
    output logic                     pay_rd,
    input  wire cam_udp_pkg::byte_t  pay_data,
    output logic                     frame_start,
    output logic [5:0]               hdr_idx,
    input  wire cam_udp_pkg::byte_t  hdr_byte,
    input  wire                      hdr_ready,
    output logic                     frame_done,
    output cam_udp_pkg::byte_t       gmii_txd,
    output logic                     gmii_tx_en
);
    import cam_udp_pkg::*;

    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320; // 0x04C11DB7 bit-reversed

    typedef enum logic [2:0] {IDLE, WAIT_HDR, PREAMBLE, HEADER, PAYLOAD, FCS, GAP} state_t;

    state_t       state;
    logic [10:0]  cnt;
    len_t         len_q;
    logic [31:0]  crc;
    byte_t        data_byte;

    function automatic logic [31:0] crc32_byte(input logic [31:0] c, input byte_t d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i])
                r = (r >> 1) ^ CRC_POLY_REFL;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    assign hdr_idx   = cnt[5:0];
    assign data_byte = (state == HEADER) ? hdr_byte : pay_data;

    // read one byte ahead of the payload slot
    assign pay_rd = ((state == HEADER) && (cnt == 11'(HDR_BYTES - 1))) ||
                    ((state == PAYLOAD) && (cnt != len_q - 1'b1));

    always_ff @(posedge gmii_tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            cnt         <= '0;
            len_q       <= '0;
            crc         <= '1;
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
            gmii_tx_en  <= 1'b0;
            gmii_txd    <= '0;
        end else begin
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
            cnt         <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    gmii_tx_en <= 1'b0;
                    cnt        <= '0;
                    if (enable && fill_level >= {1'b0, payload_len}) begin
                        frame_start <= 1'b1;
                        len_q       <= payload_len;
                        state       <= WAIT_HDR;
                    end
                end
                WAIT_HDR: begin
                    cnt <= '0;
                    crc <= '1;
                    if (hdr_ready)
                        state <= PREAMBLE;
                end
                PREAMBLE: begin
                    gmii_tx_en <= 1'b1;
                    if (cnt == 11'(PREAMBLE_BYTES - 1)) begin
                        gmii_txd <= 8'hD5;          // start frame delimiter
                        cnt      <= '0;
                        state    <= HEADER;
                    end else begin
                        gmii_txd <= 8'h55;
                    end
                end
                HEADER: begin
                    gmii_txd <= data_byte;
                    crc      <= crc32_byte(crc, data_byte);
                    if (cnt == 11'(HDR_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    gmii_txd <= data_byte;
                    crc      <= crc32_byte(crc, data_byte);
                    if (cnt == len_q - 1'b1) begin
                        cnt   <= '0;
                        state <= FCS;
                    end
                end
                FCS: begin
                    gmii_txd <= ~crc[cnt[1:0] * 8 +: 8]; // lsb first
                    if (cnt == 11'd3) begin
                        frame_done <= 1'b1;
                        cnt        <= '0;
                        state      <= GAP;
                    end
                end
                GAP: begin
                    gmii_tx_en <= 1'b0;
                    if (cnt == 11'(IFG_CYCLES - 1))
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cam_udp_top.sv
// single clock gmii_tx_clk drives everything, camera port included; no RGMII or receive path
`timescale 1ns/10ps
`default_nettype none

module cam_udp_top #(
    parameter int                FIFO_DEPTH = 2048,
    parameter cam_udp_pkg::mac_t LOCAL_MAC  = 48'h02_00_00_00_00_01
) (
    input  wire                         gmii_tx_clk,
    input  wire                         arst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire cam_udp_pkg::apb_addr_t paddr,
    input  wire [31:0]                  pwdata,
    output wire [31:0]                  prdata,
    output wire                         pready,
    output wire                         pslverr,
    input  wire cam_udp_pkg::byte_t     cam_data,
    input  wire                         cam_href,
    input  wire                         cam_vsync,
    output wire cam_udp_pkg::byte_t     gmii_txd,
    output wire                         gmii_tx_en
);
    import cam_udp_pkg::*;

    logic        enable;
    len_t        payload_len;
    mac_t        dst_mac;
    ip_t         dst_ip;
    ip_t         src_ip;
    port_t       src_port;
    port_t       dst_port;
    logic        clr_overflow;
    logic        overflow;
    logic [11:0] fill_level;
    logic        pay_rd;
    byte_t       pay_data;
    logic        frame_start;
    logic        frame_done;
    logic [5:0]  hdr_idx;
    byte_t       hdr_byte;
    logic        hdr_ready;

    apb_cfg_regs cfg_i (
        .clk(gmii_tx_clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .overflow(overflow), .frame_done(frame_done),
        .enable(enable), .payload_len(payload_len), .dst_mac(dst_mac),
        .dst_ip(dst_ip), .src_ip(src_ip), .src_port(src_port),
        .dst_port(dst_port), .clr_overflow(clr_overflow)
    );

    cam_line_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) buf_i (
        .gmii_tx_clk(gmii_tx_clk), .arst_n(arst_n), .enable(enable),
        .cam_data(cam_data), .cam_href(cam_href), .cam_vsync(cam_vsync),
        .pay_rd(pay_rd), .pay_data(pay_data), .fill_level(fill_level),
        .clr_overflow(clr_overflow), .overflow(overflow)
    );

    udp_header_gen #(.LOCAL_MAC(LOCAL_MAC)) hdr_i (
        .gmii_tx_clk(gmii_tx_clk), .arst_n(arst_n), .frame_start(frame_start),
        .payload_len(payload_len), .dst_mac(dst_mac), .dst_ip(dst_ip),
        .src_ip(src_ip), .src_port(src_port), .dst_port(dst_port),
        .hdr_idx(hdr_idx), .hdr_byte(hdr_byte), .hdr_ready(hdr_ready)
    );

    gmii_frame_tx tx_i (
        .gmii_tx_clk(gmii_tx_clk), .arst_n(arst_n), .enable(enable),
        .payload_len(payload_len), .fill_level(fill_level), .pay_rd(pay_rd),
        .pay_data(pay_data), .frame_start(frame_start), .hdr_idx(hdr_idx),
        .hdr_byte(hdr_byte), .hdr_ready(hdr_ready), .frame_done(frame_done),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en)
    );

endmodule

`default_nettype wire

//--- tb_cam_udp.sv
// single clock; FIFO_DEPTH 2048, payload lengths 64 and 1024; stops at the first mismatch
`timescale 1ns/10ps
`default_nettype none

module tb_cam_udp;
    import cam_udp_pkg::*;

    localparam int   FIFO_DEPTH  = 2048;
    localparam mac_t LOCAL_MAC   = 48'h02_00_00_00_00_01;
    localparam int   CLK_NS      = 100;
    localparam int   N_SHORT     = 3;
    localparam int   LEN_SHORT   = 64;
    localparam int   N_LONG      = 2;
    localparam int   LEN_LONG    = 1024;
    localparam int   OVF_BYTES   = FIFO_DEPTH + 16;
    localparam int   RESET_NS    = 2 * CLK_NS;
    // per-frame budget, overflow fill and register traffic, four times over
    localparam int   WATCHDOG_NS = (N_SHORT * (LEN_SHORT + 80) + N_LONG * (LEN_LONG + 80)
                                   + OVF_BYTES + 200) * CLK_NS * 4 + RESET_NS;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    byte_t       cam_data;
    logic        cam_href;
    logic        cam_vsync;
    byte_t       gmii_txd;
    logic        gmii_tx_en;

    integer      seed;
    byte_t       exp_q[$];      // camera bytes not yet seen on GMII
    byte_t       rx_bytes[$];   // frame being collected
    int          frames_seen;
    int          idle_cnt;
    logic        en_q;
    logic        tx_allowed;    // low while enable is known to be 0
    int          exp_len;
    mac_t        exp_dmac;
    ip_t         exp_dip;
    ip_t         exp_sip;
    port_t       exp_sport;
    port_t       exp_dport;

    cam_udp_top #(.FIFO_DEPTH(FIFO_DEPTH), .LOCAL_MAC(LOCAL_MAC)) dut_i (
        .gmii_tx_clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cam_data(cam_data), .cam_href(cam_href), .cam_vsync(cam_vsync),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic wait_drive_slot();
        @(posedge clk);
        #10;
    endtask

    // both transfers start and end at a drive slot
    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        wait_drive_slot();
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        wait_drive_slot();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        wait_drive_slot();
        penable = 1'b1;
        @(negedge clk);
        data = prdata;   // valid in the access cycle
        err  = pslverr;
        wait_drive_slot();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_and_verify(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        werr;
        logic        rerr;
        apb_write(addr, data, werr);
        apb_read(addr, rdata, rerr);
        assert (!werr && !rerr)
            else abort_run($sformatf("FAIL %0t: pslverr on mapped address %0h", $time, addr));
        assert (rdata == data)
            else abort_run($sformatf("FAIL %0t: register %0h reads %0h, wrote %0h",
                                     $time, addr, rdata, data));
    endtask

    task automatic set_stream(input int len, input port_t sport, input port_t dport);
        logic err;
        exp_len   = len;
        exp_sport = sport;
        exp_dport = dport;
        apb_write(REG_LEN, 32'(len), err);
        apb_write(REG_PORTS, {sport, dport}, err);
    endtask

    // vsync pulse, then lines of random pixels with blanking between them
    task automatic camera_frame(input int lines, input int line_len, input bit record);
        logic [31:0] rnd;
        cam_vsync = 1'b1;
        repeat (3) wait_drive_slot();
        cam_vsync = 1'b0;           // falling edge arms capture
        repeat (2) wait_drive_slot();
        for (int l = 0; l < lines; l++) begin
            for (int b = 0; b < line_len; b++) begin
                rnd      = $random(seed);
                cam_data = rnd[7:0];
                cam_href = 1'b1;
                if (record)
                    exp_q.push_back(rnd[7:0]);
                wait_drive_slot();
            end
            cam_href = 1'b0;
            cam_data = 8'h00;
            repeat (4) wait_drive_slot();
        end
    endtask

    function automatic logic [47:0] be_field(input int off, input int nbytes);
        logic [47:0] v;
        v = '0;
        for (int i = 0; i < nbytes; i++)
            v = {v[39:0], rx_bytes[off + i]};
        return v;
    endfunction

    // reflected CRC-32, data xored in first, then eight shift steps
    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input byte_t b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        repeat (8)
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        return c;
    endfunction

    task automatic check_value(input string what, input logic [47:0] got,
                               input logic [47:0] exp);
        assert (got == exp)
            else abort_run($sformatf("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp));
    endtask

    task automatic check_frame();
        int          n;
        int          pay0;
        logic [31:0] sum;
        logic [31:0] crc;
        logic [31:0] fcs;
        byte_t       want;
        n    = PREAMBLE_BYTES + HDR_BYTES + exp_len + 4;
        pay0 = PREAMBLE_BYTES + HDR_BYTES;
        assert (rx_bytes.size() == n)
            else abort_run($sformatf("FAIL %0t: frame of %0d bytes, expected %0d",
                                     $time, rx_bytes.size(), n));
        for (int i = 0; i < PREAMBLE_BYTES; i++) begin
            want = (i == PREAMBLE_BYTES - 1) ? 8'hD5 : 8'h55;
            check_value("preamble byte", 48'(rx_bytes[i]), 48'(want));
        end
        check_value("destination MAC", be_field(8, 6), exp_dmac);
        check_value("source MAC", be_field(14, 6), LOCAL_MAC);
        check_value("ethertype", be_field(20, 2), 48'h0800);
        check_value("version and IHL", be_field(22, 2), 48'h4500);
        check_value("IP total length", be_field(24, 2), 48'(exp_len + 28));
        check_value("IP flags", be_field(28, 2), 48'h4000);
        check_value("TTL and protocol", be_field(30, 2), {32'd0, 8'd64, 8'd17});
        check_value("source IP", be_field(34, 4), 48'(exp_sip));
        check_value("destination IP", be_field(38, 4), 48'(exp_dip));
        check_value("source port", be_field(42, 2), 48'(exp_sport));
        check_value("destination port", be_field(44, 2), 48'(exp_dport));
        check_value("UDP length", be_field(46, 2), 48'(exp_len + 8));
        check_value("UDP checksum", be_field(48, 2), 48'h0);
        sum = '0;
        for (int i = 0; i < 10; i++)
            sum = sum + 32'(be_field(22 + 2 * i, 2));
        while (sum[31:16] != 16'd0)
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        check_value("IP header sum", 48'(sum), 48'hFFFF);
        for (int i = 0; i < exp_len; i++) begin
            assert (exp_q.size() > 0)
                else abort_run("GMII frame carries more payload than the camera sent");
            want = exp_q.pop_front();
            check_value("payload byte", 48'(rx_bytes[pay0 + i]), 48'(want));
        end
        crc = '1;
        for (int i = PREAMBLE_BYTES; i < n - 4; i++)
            crc = crc32_update(crc, rx_bytes[i]);
        fcs = {rx_bytes[n - 1], rx_bytes[n - 2], rx_bytes[n - 3], rx_bytes[n - 4]};
        check_value("FCS", {16'd0, fcs}, {16'd0, ~crc});
    endtask

    // GMII decoder and per-cycle checks, sampled mid-cycle
    always @(negedge clk) begin
        assert (pready) else abort_run($sformatf("FAIL %0t: pready is low", $time));
        if (!tx_allowed) begin
            assert (!gmii_tx_en)
                else abort_run($sformatf("FAIL %0t: gmii_tx_en high while disabled", $time));
        end
        if (gmii_tx_en) begin
            if (!en_q && frames_seen > 0) begin
                assert (idle_cnt >= IFG_CYCLES)
                    else abort_run($sformatf("FAIL %0t: gap of %0d cycles", $time, idle_cnt));
            end
            rx_bytes.push_back(gmii_txd);
        end else if (en_q) begin
            check_frame();
            rx_bytes.delete();
            frames_seen = frames_seen + 1;
            idle_cnt    = 1;
        end else begin
            idle_cnt = idle_cnt + 1;
        end
        en_q = gmii_tx_en;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Simulation timed out before all frames were received and checked");
    end

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        seed        = 32'h91d3_b3b7;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        cam_data    = '0;
        cam_href    = 1'b0;
        cam_vsync   = 1'b0;
        frames_seen = 0;
        idle_cnt    = 0;
        en_q        = 1'b0;
        tx_allowed  = 1'b0;
        exp_len     = 0;
        repeat (2) @(posedge clk);
        #10;
        arst_n = 1'b1;

        apb_read(REG_STAT, rdata, err);
        check_value("status after reset", 48'(rdata), 48'h0);
        write_and_verify(REG_LEN, 32'h0000_05A5);
        write_and_verify(REG_DMAC_LO, 32'hA5A5_5A5A);
        write_and_verify(REG_DMAC_HI, 32'h0000_C33C);
        write_and_verify(REG_DIP, 32'h1234_5678);
        write_and_verify(REG_SIP, 32'h8765_4321);
        write_and_verify(REG_PORTS, 32'hDEAD_BEEF);
        write_and_verify(REG_CTRL, 32'h0000_0001);   // empty FIFO, no frame can start
        write_and_verify(REG_CTRL, 32'h0000_0000);
        apb_read(6'h20, rdata, err);
        assert (err) else abort_run($sformatf("FAIL %0t: no pslverr on read of 0x20", $time));
        apb_write(6'h3C, 32'hFFFF_FFFF, err);
        assert (err) else abort_run($sformatf("FAIL %0t: no pslverr on write of 0x3C", $time));

        exp_dmac = 48'h10_22_33_44_55_66;
        exp_dip  = 32'hC0A8_0164;
        exp_sip  = 32'hC0A8_010A;
        apb_write(REG_DMAC_LO, exp_dmac[31:0], err);
        apb_write(REG_DMAC_HI, {16'd0, exp_dmac[47:32]}, err);
        apb_write(REG_DIP, exp_dip, err);
        apb_write(REG_SIP, exp_sip, err);
        set_stream(LEN_SHORT, 16'h1F90, 16'h2328);
        tx_allowed = 1'b1;
        apb_write(REG_CTRL, 32'd1, err);

        camera_frame(N_SHORT, LEN_SHORT, 1'b1);
        wait (frames_seen == N_SHORT);
        wait_drive_slot();

        // FIFO is empty here, so the new length applies from the next frame
        set_stream(LEN_LONG, 16'h1388, 16'h1389);
        camera_frame(8, N_LONG * LEN_LONG / 8, 1'b1);
        wait (frames_seen == N_SHORT + N_LONG);
        wait_drive_slot();
        assert (exp_q.size() == 0)
            else abort_run("Camera bytes were left over after the last frame");

        apb_write(REG_CTRL, 32'd0, err);
        tx_allowed = 1'b0;
        apb_read(REG_STAT, rdata, err);
        assert (!rdata[31]) else abort_run($sformatf("FAIL %0t: early overflow", $time));
        camera_frame(1, OVF_BYTES, 1'b0);
        apb_read(REG_STAT, rdata, err);
        assert (rdata[31]) else abort_run($sformatf("FAIL %0t: overflow not set", $time));
        apb_write(REG_STAT, 32'h8000_0000, err);
        repeat (2) wait_drive_slot();   // clear pulse lands one edge after the write
        apb_read(REG_STAT, rdata, err);
        assert (!rdata[31]) else abort_run($sformatf("FAIL %0t: overflow not cleared", $time));

        if (rdata[15:0] == 16'(frames_seen) && frames_seen == N_SHORT + N_LONG) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run($sformatf("FAIL %0t: frame count %0d, decoded %0d frames",
                                $time, rdata[15:0], frames_seen));
        end
    end

endmodule

`default_nettype wire

//--- cam_udp.f
cam_udp_pkg.sv
apb_cfg_regs.sv
cam_line_buffer.sv
udp_header_gen.sv
gmii_frame_tx.sv
cam_udp_top.sv
tb_cam_udp.sv

//--- Bender.yml
package:
  name: cam_udp

sources:
  - cam_udp_pkg.sv
  - apb_cfg_regs.sv
  - cam_line_buffer.sv
  - udp_header_gen.sv
  - gmii_frame_tx.sv
  - cam_udp_top.sv
  - target: test
    files:
      - tb_cam_udp.sv
